// ==== Makefile ====
TOP := tb_core

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "sim failed" sim.log; then exit 1; fi

obj_dir/V$(TOP): project.f core_pkg.sv fetch_stage.sv decode_stage.sv regfile.sv \
		execute_stage.sv core_top.sv tb_core.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

lint:
	verilator --lint-only -Wall --top-module core_top core_pkg.sv fetch_stage.sv \
		decode_stage.sv regfile.sv execute_stage.sv core_top.sv

clean:
	rm -rf obj_dir sim.log

// ==== core_pkg.sv ====
/*
 * Shared definitions for the integer core: data widths, value typedefs,
 * accepted major opcodes, ALU operation encoding and the boot address
 */
package core_pkg;

    // ------------------------------------------------------------
    // Widths and value types
    // ------------------------------------------------------------
    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;

    // First fetch after reset
    localparam addr_t BOOT_ADDR = 32'h0000_1000;

    // ------------------------------------------------------------
    // RV32I major opcodes handled by this core
    // ------------------------------------------------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;

    // ALU operation, chosen in decode and carried to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

// ==== core_top.sv ====
/*
 * Core top level: fetch, decode, register file and execute
 */
module core_top import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      fetch_enable_i,
    // Instruction bus
    output logic      wb_cyc_o,
    output logic      wb_stb_o,
    output addr_t     wb_adr_o,
    input  instr_t    wb_dat_i,
    input  logic      wb_ack_i,
    // Commit port
    output logic      commit_valid_o,
    output addr_t     commit_pc_o,
    output reg_addr_t commit_rd_o,
    output xlen_t     commit_data_o,
    output logic      commit_we_o,
    output logic      commit_illegal_o
);

    // Fetch to decode
    logic      if_valid;
    instr_t    if_instr;
    addr_t     if_pc;
    // Decode and register file
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    xlen_t     rdata_a;
    xlen_t     rdata_b;
    // Decode to execute
    logic      is_valid;
    alu_op_e   is_op;
    xlen_t     is_operand_a;
    xlen_t     is_operand_b;
    reg_addr_t is_rd;
    logic      is_we;
    logic      is_illegal;
    addr_t     is_pc;
    // Write-back
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;

    fetch_stage i_fetch (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_enable_i ( fetch_enable_i ),
        .wb_cyc_o       ( wb_cyc_o       ),
        .wb_stb_o       ( wb_stb_o       ),
        .wb_adr_o       ( wb_adr_o       ),
        .wb_dat_i       ( wb_dat_i       ),
        .wb_ack_i       ( wb_ack_i       ),
        .if_valid_o     ( if_valid       ),
        .if_instr_o     ( if_instr       ),
        .if_pc_o        ( if_pc          )
    );

    decode_stage i_decode (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .if_valid_i     ( if_valid       ),
        .if_instr_i     ( if_instr       ),
        .if_pc_i        ( if_pc          ),
        .raddr_a_o      ( raddr_a        ),
        .raddr_b_o      ( raddr_b        ),
        .rdata_a_i      ( rdata_a        ),
        .rdata_b_i      ( rdata_b        ),
        .is_valid_o     ( is_valid       ),
        .is_op_o        ( is_op          ),
        .is_operand_a_o ( is_operand_a   ),
        .is_operand_b_o ( is_operand_b   ),
        .is_rd_o        ( is_rd          ),
        .is_we_o        ( is_we          ),
        .is_illegal_o   ( is_illegal     ),
        .is_pc_o        ( is_pc          )
    );

    regfile i_regfile (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .raddr_a_i      ( raddr_a        ),
        .raddr_b_i      ( raddr_b        ),
        .rdata_a_o      ( rdata_a        ),
        .rdata_b_o      ( rdata_b        ),
        .we_i           ( we             ),
        .waddr_i        ( waddr          ),
        .wdata_i        ( wdata          )
    );

    execute_stage i_execute (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .is_valid_i       ( is_valid         ),
        .is_op_i          ( is_op            ),
        .is_operand_a_i   ( is_operand_a     ),
        .is_operand_b_i   ( is_operand_b     ),
        .is_rd_i          ( is_rd            ),
        .is_we_i          ( is_we            ),
        .is_illegal_i     ( is_illegal       ),
        .is_pc_i          ( is_pc            ),
        .we_o             ( we               ),
        .waddr_o          ( waddr            ),
        .wdata_o          ( wdata            ),
        .commit_valid_o   ( commit_valid_o   ),
        .commit_pc_o      ( commit_pc_o      ),
        .commit_rd_o      ( commit_rd_o      ),
        .commit_data_o    ( commit_data_o    ),
        .commit_we_o      ( commit_we_o      ),
        .commit_illegal_o ( commit_illegal_o )
    );

endmodule

// ==== decode_stage.sv ====
/*
 * Instruction decode: ALU, LUI and AUIPC decoding, immediates,
 * operand selection and the issue register towards execute
 */
module decode_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // From fetch
    input  logic      if_valid_i,
    input  instr_t    if_instr_i,
    input  addr_t     if_pc_i,
    // Register file read ports
    output reg_addr_t raddr_a_o,
    output reg_addr_t raddr_b_o,
    input  xlen_t     rdata_a_i,
    input  xlen_t     rdata_b_i,
    // Issue register
    output logic      is_valid_o,
    output alu_op_e   is_op_o,
    output xlen_t     is_operand_a_o,
    output xlen_t     is_operand_b_o,
    output reg_addr_t is_rd_o,
    output logic      is_we_o,
    output logic      is_illegal_o,
    output addr_t     is_pc_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    logic       legal;
    alu_op_e    alu_op;
    xlen_t      operand_a;
    xlen_t      operand_b;

    // funct3 to ALU operation, alt selects SUB or SRA
    function automatic alu_op_e alu_op_for(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode    = if_instr_i[6:0];
    assign rd        = if_instr_i[11:7];
    assign funct3    = if_instr_i[14:12];
    assign funct7    = if_instr_i[31:25];
    assign raddr_a_o = if_instr_i[19:15];
    assign raddr_b_o = if_instr_i[24:20];

    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_u = {if_instr_i[31:12], 12'b0};

    // ------------------------------------------------------------
    // Decoder and operand selection
    // ------------------------------------------------------------
    always_comb begin
        legal     = 1'b0;
        alu_op    = ALU_ADD;
        operand_a = rdata_a_i;
        operand_b = imm_i;
        case (opcode)
            OPCODE_OP: begin
                operand_b = rdata_b_i;
                alu_op    = alu_op_for(funct3, funct7[5]);
                legal     = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPCODE_OP_IMM: begin
                // No SUBI, so bit 30 only matters for shifts
                alu_op = alu_op_for(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
            end
            OPCODE_LUI: begin
                legal     = 1'b1;
                operand_a = '0;
                operand_b = imm_u;
            end
            OPCODE_AUIPC: begin
                legal     = 1'b1;
                operand_a = if_pc_i;
                operand_b = imm_u;
            end
            default: legal = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Issue register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            is_valid_o   <= 1'b0;
            is_we_o      <= 1'b0;
            is_illegal_o <= 1'b0;
        end else begin
            is_valid_o   <= if_valid_i;
            // x0 is never written
            is_we_o      <= if_valid_i && legal && (rd != '0);
            is_illegal_o <= if_valid_i && !legal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (if_valid_i) begin
            is_op_o        <= alu_op;
            is_operand_a_o <= operand_a;
            is_operand_b_o <= operand_b;
            is_rd_o        <= rd;
            is_pc_o        <= if_pc_i;
        end
    end

endmodule

// ==== execute_stage.sv ====
/*
 * Execute: ALU, register write-back and the registered commit port
 */
module execute_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // Issue register
    input  logic      is_valid_i,
    input  alu_op_e   is_op_i,
    input  xlen_t     is_operand_a_i,
    input  xlen_t     is_operand_b_i,
    input  reg_addr_t is_rd_i,
    input  logic      is_we_i,
    input  logic      is_illegal_i,
    input  addr_t     is_pc_i,
    // Register file write port
    output logic      we_o,
    output reg_addr_t waddr_o,
    output xlen_t     wdata_o,
    // Commit port
    output logic      commit_valid_o,
    output addr_t     commit_pc_o,
    output reg_addr_t commit_rd_o,
    output xlen_t     commit_data_o,
    output logic      commit_we_o,
    output logic      commit_illegal_o
);

    xlen_t      result;
    logic [4:0] shamt;

    assign shamt = is_operand_b_i[4:0];

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    always_comb begin
        case (is_op_i)
            ALU_ADD:  result = is_operand_a_i + is_operand_b_i;
            ALU_SUB:  result = is_operand_a_i - is_operand_b_i;
            ALU_SLL:  result = is_operand_a_i << shamt;
            ALU_SLT:  result = {31'b0, $signed(is_operand_a_i) < $signed(is_operand_b_i)};
            ALU_SLTU: result = {31'b0, is_operand_a_i < is_operand_b_i};
            ALU_XOR:  result = is_operand_a_i ^ is_operand_b_i;
            ALU_SRL:  result = is_operand_a_i >> shamt;
            ALU_SRA:  result = xlen_t'($signed(is_operand_a_i) >>> shamt);
            ALU_OR:   result = is_operand_a_i | is_operand_b_i;
            ALU_AND:  result = is_operand_a_i & is_operand_b_i;
            default:  result = '0;
        endcase
    end

    // Write-back lands on the same edge as the commit record
    assign we_o    = is_valid_i & is_we_i;
    assign waddr_o = is_rd_i;
    assign wdata_o = result;

    // ------------------------------------------------------------
    // Commit register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_o   <= 1'b0;
            commit_we_o      <= 1'b0;
            commit_illegal_o <= 1'b0;
        end else begin
            commit_valid_o   <= is_valid_i;
            commit_we_o      <= we_o;
            commit_illegal_o <= is_valid_i & is_illegal_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_valid_i) begin
            commit_pc_o   <= is_pc_i;
            commit_rd_o   <= is_rd_i;
            commit_data_o <= result;
        end
    end

    // Decode must have filtered x0 and illegal words
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_we_o |-> (commit_rd_o != '0));

    a_illegal_no_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(commit_we_o && commit_illegal_o));

endmodule

// ==== fetch_stage.sv ====
/*
 * Instruction fetch: registered fetch enable, program counter,
 * Wishbone classic read master and the fetched-instruction register
 */
module fetch_stage import core_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   fetch_enable_i,
    // Instruction bus
    output logic   wb_cyc_o,
    output logic   wb_stb_o,
    output addr_t  wb_adr_o,
    input  instr_t wb_dat_i,
    input  logic   wb_ack_i,
    // Towards decode
    output logic   if_valid_o,
    output instr_t if_instr_o,
    output addr_t  if_pc_o
);

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e state_q, state_d;
    logic         fetch_en_q;
    addr_t        pc_q;
    logic         ack;

    // Request is open for as long as we wait for the ack
    assign wb_cyc_o = (state_q == FETCH_WAIT);
    assign wb_stb_o = (state_q == FETCH_WAIT);
    assign wb_adr_o = pc_q;
    assign ack      = wb_stb_o & wb_ack_i;

    // ------------------------------------------------------------
    // Bus FSM
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: begin
                if (fetch_en_q) begin
                    state_d = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                // Back-to-back requests while enabled, otherwise park
                if (ack && !fetch_en_q) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= FETCH_IDLE;
            fetch_en_q <= 1'b0;
            pc_q       <= BOOT_ADDR;
            if_valid_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            fetch_en_q <= fetch_enable_i;
            if_valid_o <= ack;
            if (ack) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // Acked word together with the address it came from
    always_ff @(posedge clk_i) begin
        if (ack) begin
            if_instr_o <= wb_dat_i;
            if_pc_o    <= pc_q;
        end
    end

    // ------------------------------------------------------------
    // Wishbone master rules
    // ------------------------------------------------------------
    // Request held unchanged until it is acked
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)));

endmodule

// ==== project.f ====
core_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
execute_stage.sv
core_top.sv
tb_core.sv

// ==== regfile.sv ====
/*
 * General purpose registers x1..x31, x0 hard-wired to zero,
 * two write-first read ports and one write port
 */
module regfile import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output xlen_t     rdata_a_o,
    output xlen_t     rdata_b_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  xlen_t     wdata_i
);

    xlen_t     regs [1:31];
    reg_addr_t raddr [2];
    xlen_t     rdata [2];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign raddr[0]  = raddr_a_i;
    assign raddr[1]  = raddr_b_i;
    assign rdata_a_o = rdata[0];
    assign rdata_b_o = rdata[1];

    // Same-cycle write is forwarded to the reader
    for (genvar p = 0; p < 2; p++) begin : g_read
        assign rdata[p] = (raddr[p] == '0)                ? '0 :
                          (we_i && waddr_i == raddr[p])   ? wdata_i :
                                                            regs[raddr[p]];
    end

endmodule

// ==== tb_core.sv ====
/*
 * Testbench for the integer core: random instruction memory behind a
 * Wishbone slave with wait states, reference model, commit checks,
 * fetch-enable pause and timeout
 */
module tb_core import core_pkg::*; ();

    localparam int unsigned MEM_WORDS  = 256;
    localparam int unsigned PAUSE_AT   = 100;
    localparam int unsigned STOP_AT    = 240;
    // Worst case four bus cycles per word, plus reset, pause and drain
    localparam int unsigned MAX_CYCLES = MEM_WORDS * 5 + 200;

    logic      clk_i;
    logic      rst_ni;
    logic      fetch_enable;
    logic      wb_cyc;
    logic      wb_stb;
    addr_t     wb_adr;
    instr_t    wb_dat;
    logic      wb_ack;
    logic      commit_valid;
    addr_t     commit_pc;
    reg_addr_t commit_rd;
    xlen_t     commit_data;
    logic      commit_we;
    logic      commit_illegal;

    instr_t      mem      [MEM_WORDS];
    xlen_t       exp_data [MEM_WORDS];
    logic        exp_we   [MEM_WORDS];
    logic        exp_ill  [MEM_WORDS];
    addr_t       fetch_addr;
    logic        bus_busy;
    int unsigned acks, commits, checks, errors, errors_mark, cycles, waits_left;
    int unsigned n_illegal, n_x0, n_bypass, stopped_at;

    core_top i_dut (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_ni         ),
        .fetch_enable_i   ( fetch_enable   ),
        .wb_cyc_o         ( wb_cyc         ),
        .wb_stb_o         ( wb_stb         ),
        .wb_adr_o         ( wb_adr         ),
        .wb_dat_i         ( wb_dat         ),
        .wb_ack_i         ( wb_ack         ),
        .commit_valid_o   ( commit_valid   ),
        .commit_pc_o      ( commit_pc      ),
        .commit_rd_o      ( commit_rd      ),
        .commit_data_o    ( commit_data    ),
        .commit_we_o      ( commit_we      ),
        .commit_illegal_o ( commit_illegal )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-16s done: %0d fetched, %0d retired, %0d errors",
                 name, acks, commits, errors - errors_mark);
        errors_mark = errors;
    endtask

    // ------------------------------------------------------------
    // Instruction image and reference model
    // ------------------------------------------------------------
    // RV32I encoding rules for the accepted opcodes
    function automatic logic is_legal(input instr_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OPCODE_OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            OPCODE_OP_IMM: return f3 == 3'd1 ? f7 == 7'h00 :
                                  f3 == 3'd5 ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            OPCODE_LUI, OPCODE_AUIPC: return 1'b1;
            default:       return 1'b0;
        endcase
    endfunction

    function automatic instr_t random_word();
        instr_t     w;
        logic [2:0] f3;
        logic       alt;
        w   = $urandom;
        f3  = w[14:12];
        alt = w[30] && (f3 == 3'd0 || f3 == 3'd5);
        // About one word in ten is illegal
        if ($urandom_range(9, 0) == 0) begin
            if (is_legal(w)) w[6:0] = 7'b1110011;
            return w;
        end
        case ($urandom_range(3, 0))
            0: begin
                w[6:0]   = OPCODE_OP;
                w[31:25] = {1'b0, alt, 5'b0};
            end
            1: begin
                w[6:0] = OPCODE_OP_IMM;
                if (f3 == 3'd1 || f3 == 3'd5) w[31:25] = {1'b0, alt, 5'b0};
            end
            2:       w[6:0] = OPCODE_LUI;
            default: w[6:0] = OPCODE_AUIPC;
        endcase
        return w;
    endfunction

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return xlen_t'($signed(a) < $signed(b));
            3'd3:    return xlen_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = random_word();
            // Chain onto the previous rd to hit the write-first bypass
            if (i > 0 && $urandom_range(3, 0) == 0 && is_legal(mem[i-1]) &&
                mem[i-1][11:7] != 5'd0 && mem[i][6:0] inside {OPCODE_OP, OPCODE_OP_IMM}) begin
                mem[i][19:15] = mem[i-1][11:7];
                n_bypass++;
            end
        end
    endtask

    // Runs the image in program order
    task automatic build_expected();
        xlen_t  regs [32];
        instr_t w;
        xlen_t  a;
        xlen_t  b;
        xlen_t  imm_u;
        regs = '{default: '0};
        for (int i = 0; i < MEM_WORDS; i++) begin
            w          = mem[i];
            imm_u      = {w[31:12], 12'b0};
            a          = regs[w[19:15]];
            b          = (w[6:0] == OPCODE_OP) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
            exp_ill[i] = !is_legal(w);
            exp_we[i]  = !exp_ill[i] && w[11:7] != 5'd0;
            case (w[6:0])
                OPCODE_LUI:   exp_data[i] = imm_u;
                OPCODE_AUIPC: exp_data[i] = BOOT_ADDR + 32'(4 * i) + imm_u;
                default:      exp_data[i] = alu_ref(w[14:12],
                                  w[30] && (w[6:0] == OPCODE_OP || w[14:12] == 3'd5), a, b);
            endcase
            if (exp_we[i]) regs[w[11:7]] = exp_data[i];
        end
    endtask

    // Out-of-range reads return an illegal word
    function automatic instr_t read_word(input addr_t adr);
        int unsigned idx;
        idx = (adr - BOOT_ADDR) >> 2;
        if (idx < MEM_WORDS) return mem[idx];
        return {adr[31:7], 7'b1111111};
    endfunction

    // ------------------------------------------------------------
    // Bus slave and monitors
    // ------------------------------------------------------------
    initial begin
        wb_ack     = 1'b0;
        wb_dat     = '0;
        waits_left = 0;
        forever begin
            @(posedge clk_i);
            #2;
            wb_ack = 1'b0;
            if (wb_stb) begin
                if (waits_left == 0) begin
                    wb_ack     = 1'b1;
                    wb_dat     = read_word(wb_adr);
                    waits_left = $urandom_range(3, 0);
                end else begin
                    waits_left--;
                end
            end
        end
    end

    always @(negedge clk_i) begin
        bus_busy = wb_cyc;
        if (!rst_ni) begin
            compare("wb_cyc_o", 1'b0, wb_cyc);
            compare("wb_stb_o", 1'b0, wb_stb);
            compare("commit_valid_o", 1'b0, commit_valid);
            compare("commit_we_o", 1'b0, commit_we);
            compare("commit_illegal_o", 1'b0, commit_illegal);
        end else begin
            // A strobe is only legal inside a bus cycle
            if (wb_stb) begin
                compare("wb_cyc_o", 1'b1, wb_cyc);
            end
            if (wb_stb && wb_ack) begin
                compare("wb_adr_o", fetch_addr, wb_adr);
                if (acks >= MEM_WORDS) begin
                    errors++;
                    $display("fetch past the end of the instruction memory at %0t", $time);
                end
                fetch_addr = fetch_addr + 32'd4;
                acks++;
            end
            if (commit_valid && (commits >= acks || commits >= MEM_WORDS)) begin
                errors++;
                $display("retire at %0t without a matching fetched word", $time);
            end else if (commit_valid) begin
                compare("commit_pc_o", BOOT_ADDR + 32'(4 * commits), commit_pc);
                compare("commit_illegal_o", exp_ill[commits], commit_illegal);
                compare("commit_we_o", exp_we[commits], commit_we);
                if (!exp_ill[commits]) begin
                    compare("commit_rd_o", mem[commits][11:7], commit_rd);
                    compare("commit_data_o", exp_data[commits], commit_data);
                end
                if (exp_ill[commits]) n_illegal++;
                else if (mem[commits][11:7] == 5'd0) n_x0++;
                commits++;
            end
        end
    end

    // Waits until the bus is idle and every fetched word has retired
    task automatic drain();
        do @(posedge clk_i); while (bus_busy || commits != acks);
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'h2cf4_a8b6));
        rst_ni       = 1'b0;
        fetch_enable = 1'b0;
        fetch_addr   = BOOT_ADDR;
        bus_busy     = 1'b0;
        fill_memory();
        build_expected();

        repeat (8) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            compare("wb_cyc_o", 1'b0, wb_cyc);
            compare("commit_valid_o", 1'b0, commit_valid);
        end
        @(posedge clk_i);
        #2 fetch_enable = 1'b1;
        do @(negedge clk_i); while (!wb_stb);
        compare("wb_adr_o", BOOT_ADDR, wb_adr);
        end_test("reset_state");

        while (acks < PAUSE_AT) @(posedge clk_i);
        end_test("bus_and_alu");

        #2 fetch_enable = 1'b0;
        drain();
        stopped_at = acks;
        repeat (10) begin
            @(negedge clk_i);
            compare("wb_cyc_o", 1'b0, wb_cyc);
            compare("commit_valid_o", 1'b0, commit_valid);
        end
        @(posedge clk_i);
        compare("fetches while disabled", stopped_at, acks);
        #2 fetch_enable = 1'b1;
        end_test("fetch_enable");

        while (acks < STOP_AT) @(posedge clk_i);
        #2 fetch_enable = 1'b0;
        drain();
        end_test("run_to_end");

        if (n_illegal == 0 || n_x0 == 0 || n_bypass == 0) begin
            errors++;
            $display("image lacks illegal words, x0 writes or bypass pairs");
        end
        $display("x0 writes %0d, illegal words %0d, bypass pairs %0d",
                 n_x0, n_illegal, n_bypass);
        end_test("x0_and_illegal");

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
